/* Bender.yml */
package:
  name: div_unit

sources:
  - div_pkg.sv
  - div_decode.sv
  - div_execute.sv
  - div_result.sv
  - div_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - div_checker.sv
      - tb_div_top.sv

/* div_checker.sv */
`timescale 1ns/1ps

module div_checker (
	input logic              clk,
	input logic              rst_n,
	input logic              in_ready,
	input logic              out_valid,
	input logic              out_ready,
	input div_pkg::div_rsp_t out_rsp
);

	int err_cnt = 0;

	// Response must hold until the consumer takes it
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_rsp))
	else begin
		$error("out_valid or out_rsp changed while out_ready was low");
		err_cnt++;
	end

	reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
	else begin
		$error("out_valid high in the cycle after reset");
		err_cnt++;
	end

	ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready == (!out_valid || out_ready))
	else begin
		$error("in_ready does not follow the advance rule");
		err_cnt++;
	end

endmodule

bind div_top div_checker div_checker_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_rsp   (out_rsp)
);

/* div_decode.sv */
`timescale 1ns/1ps

module div_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                advance,
	input  logic                in_valid,
	input  div_pkg::div_req_t   in_req,
	output logic                stage_valid,
	output div_pkg::div_stage_t stage
);

	div_pkg::special_e special;

	// Special cases that skip the non-restoring result
	always_comb begin
		if (in_req.divisor == '0) begin
			special = div_pkg::spec_div_zero;
		end else if (in_req.dividend == div_pkg::data_min && in_req.divisor == '1) begin
			// Divisor of all ones is minus one
			special = div_pkg::spec_overflow;
		end else begin
			special = div_pkg::spec_none;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else if (advance) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			stage.tag           <= in_req.tag;
			stage.dividend      <= in_req.dividend;
			stage.divisor       <= in_req.divisor;
			stage.quotient      <= '0;
			// Sign fill so that {remainder, dividend} is the extended dividend
			stage.remainder     <= {(div_pkg::data_w+1){in_req.dividend[div_pkg::data_w-1]}};
			stage.orig_dividend <= in_req.dividend;
			stage.special       <= special;
		end
	end

endmodule

/* div_execute.sv */
`timescale 1ns/1ps

module div_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                advance,
	input  logic                in_valid,
	input  div_pkg::div_stage_t in_stage,
	output logic                out_valid,
	output div_pkg::div_stage_t out_stage
);

	div_pkg::div_stage_t stage_q [div_pkg::div_stages];
	logic                valid_q [div_pkg::div_stages];

	// --------------------------------------------------------------------------
	// One quotient digit per stage
	// --------------------------------------------------------------------------

	for (genvar i = 0; i < div_pkg::div_stages; i++) begin : g_step
		div_pkg::div_stage_t cur;
		div_pkg::div_stage_t nxt;
		logic                cur_valid;
		div_pkg::wide_t      shifted;
		div_pkg::data_t      dividend_sh;
		div_pkg::wide_t      divisor_x;

		if (i == 0) begin : g_src
			assign cur       = in_stage;
			assign cur_valid = in_valid;
		end else begin : g_src
			assign cur       = stage_q[i-1];
			assign cur_valid = valid_q[i-1];
		end

		// Shift the remainder:dividend pair left by one
		assign {shifted, dividend_sh} = {cur.remainder[div_pkg::data_w-1:0], cur.dividend, 1'b0};
		assign divisor_x = div_pkg::wide_t'(cur.divisor);

		always_comb begin
			nxt          = cur;
			nxt.dividend = dividend_sh;
			if (shifted[div_pkg::data_w] == cur.divisor[div_pkg::data_w-1]) begin
				nxt.remainder = shifted - divisor_x;
				nxt.quotient  = {cur.quotient[div_pkg::data_w-2:0], 1'b1};
			end else begin
				nxt.remainder = shifted + divisor_x;
				nxt.quotient  = {cur.quotient[div_pkg::data_w-2:0], 1'b0};
			end
		end

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				valid_q[i] <= 1'b0;
			end else if (advance) begin
				valid_q[i] <= cur_valid;
			end
		end

		always_ff @(posedge clk) begin
			if (advance) begin
				stage_q[i] <= nxt;
			end
		end
	end

	assign out_valid = valid_q[div_pkg::div_stages-1];
	assign out_stage = stage_q[div_pkg::div_stages-1];

endmodule

/* div_pkg.sv */
package div_pkg;

	// --------------------------------------------------------------------------
	// Widths
	// --------------------------------------------------------------------------

	localparam int data_w     = 16;
	localparam int tag_w      = 4;
	localparam int div_stages = data_w;

	typedef logic signed [data_w-1:0] data_t;

	// Partial remainder and raw quotient need one guard bit
	typedef logic signed [data_w:0] wide_t;

	// Non-restoring digits, 1 stands for +1 and 0 for -1
	typedef logic [data_w-1:0] digits_t;

	typedef logic [tag_w-1:0] tag_t;

	// Most negative operand value
	localparam data_t data_min = {1'b1, {(data_w-1){1'b0}}};

	// --------------------------------------------------------------------------
	// Request, in-flight word and response
	// --------------------------------------------------------------------------

	typedef enum logic [1:0] {
		spec_none,
		spec_div_zero,
		spec_overflow
	} special_e;

	typedef struct packed {
		tag_t  tag;
		data_t dividend;
		data_t divisor;
	} div_req_t;

	typedef struct packed {
		tag_t     tag;
		data_t    dividend;
		data_t    divisor;
		digits_t  quotient;
		wide_t    remainder;
		data_t    orig_dividend;
		special_e special;
	} div_stage_t;

	typedef struct packed {
		tag_t  tag;
		data_t quotient;
		data_t remainder;
		logic  div_zero;
	} div_rsp_t;

endpackage

/* div_result.sv */
`timescale 1ns/1ps

module div_result (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                advance,
	input  logic                in_valid,
	input  div_pkg::div_stage_t in_stage,
	output logic                out_valid,
	output div_pkg::div_rsp_t   out_rsp
);

	div_pkg::wide_t    q_raw;
	div_pkg::wide_t    q_fix;
	div_pkg::wide_t    r_fix;
	div_pkg::wide_t    divisor_x;
	div_pkg::wide_t    rem;
	div_pkg::div_rsp_t rsp;

	// --------------------------------------------------------------------------
	// Digit conversion and truncating correction
	// --------------------------------------------------------------------------

	always_comb begin
		rem       = in_stage.remainder;
		divisor_x = div_pkg::wide_t'(in_stage.divisor);
		// Q = 2*digits + 1 - 2^N, which only flips the top bit
		q_raw = {~in_stage.quotient[div_pkg::data_w-1],
			in_stage.quotient[div_pkg::data_w-2:0], 1'b1};
		q_fix = q_raw;
		r_fix = rem;
		if (rem == divisor_x) begin
			q_fix = q_raw + div_pkg::wide_t'(1);
			r_fix = '0;
		end else if (rem == -divisor_x) begin
			q_fix = q_raw - div_pkg::wide_t'(1);
			r_fix = '0;
		end else if (rem != '0 &&
			rem[div_pkg::data_w] != in_stage.orig_dividend[div_pkg::data_w-1]) begin
			// Pull the remainder back to the dividend's sign
			if (rem[div_pkg::data_w] == in_stage.divisor[div_pkg::data_w-1]) begin
				q_fix = q_raw + div_pkg::wide_t'(1);
				r_fix = rem - divisor_x;
			end else begin
				q_fix = q_raw - div_pkg::wide_t'(1);
				r_fix = rem + divisor_x;
			end
		end
	end

	always_comb begin
		rsp.tag      = in_stage.tag;
		rsp.div_zero = 1'b0;
		case (in_stage.special)
			div_pkg::spec_div_zero: begin
				rsp.quotient  = '1;
				rsp.remainder = in_stage.orig_dividend;
				rsp.div_zero  = 1'b1;
			end
			div_pkg::spec_overflow: begin
				rsp.quotient  = div_pkg::data_min;
				rsp.remainder = '0;
			end
			default: begin
				rsp.quotient  = q_fix[div_pkg::data_w-1:0];
				rsp.remainder = r_fix[div_pkg::data_w-1:0];
			end
		endcase
	end

	// Output register holds while the pipeline is stalled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out_rsp <= rsp;
		end
	end

endmodule

/* div_top.sv */
`timescale 1ns/1ps

module div_top (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              in_valid,
	output logic              in_ready,
	input  div_pkg::div_req_t in_req,

	output logic              out_valid,
	input  logic              out_ready,
	output div_pkg::div_rsp_t out_rsp
);

	logic                advance;
	logic                dec_valid;
	div_pkg::div_stage_t dec_stage;
	logic                exe_valid;
	div_pkg::div_stage_t exe_stage;

	// Whole pipeline moves together, stalls only on a blocked output
	assign advance  = !out_valid || out_ready;
	assign in_ready = advance;

	div_decode div_decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.advance     (advance),
		.in_valid    (in_valid),
		.in_req      (in_req),
		.stage_valid (dec_valid),
		.stage       (dec_stage)
	);

	div_execute div_execute_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.advance   (advance),
		.in_valid  (dec_valid),
		.in_stage  (dec_stage),
		.out_valid (exe_valid),
		.out_stage (exe_stage)
	);

	div_result div_result_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.advance   (advance),
		.in_valid  (exe_valid),
		.in_stage  (exe_stage),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

endmodule

/* project.f */
div_pkg.sv
div_decode.sv
div_execute.sv
div_result.sv
div_top.sv
tb_clock_gen.sv
div_checker.sv
tb_div_top.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Reset held for 4 rising edges, released just after the last one
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* tb_div_top.sv */
`timescale 1ns/1ps

module tb_div_top;

	// Edges from acceptance to the edge that first samples out_valid
	localparam int latency    = 18;
	localparam int wait_limit = 200;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	div_pkg::div_req_t in_req;
	logic              out_valid;
	logic              out_ready;
	div_pkg::div_rsp_t out_rsp;

	div_pkg::div_rsp_t exp_q [$];
	logic [31:0]       lfsr = 32'hc41bc6a9;
	div_pkg::tag_t     next_tag = '0;
	logic              random_ready = 1'b0;
	int                edge_cnt = 0;
	int                err_cnt = 0;
	int                err_base = 0;
	int                tests_run = 0;
	int                n_sent = 0;
	int                n_recv = 0;
	int                accept_edge = 0;

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	div_top div_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
	end

	// --------------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------------

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr[0]) begin
				lfsr = (lfsr >> 1) ^ 32'h80200003;
			end else begin
				lfsr = lfsr >> 1;
			end
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Truncating division with the two special cases
	function automatic div_pkg::div_rsp_t model_div(input div_pkg::div_req_t req);
		div_pkg::div_rsp_t rsp;
		int                a;
		int                b;
		a = div_pkg::data_t'(req.dividend);
		b = div_pkg::data_t'(req.divisor);
		rsp.tag      = req.tag;
		rsp.div_zero = 1'b0;
		if (b == 0) begin
			rsp.quotient  = '1;
			rsp.remainder = req.dividend;
			rsp.div_zero  = 1'b1;
		end else if (a == -(2 ** (div_pkg::data_w - 1)) && b == -1) begin
			rsp.quotient  = req.dividend;
			rsp.remainder = '0;
		end else begin
			rsp.quotient  = div_pkg::data_t'(a / b);
			rsp.remainder = div_pkg::data_t'(a % b);
		end
		return rsp;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int want);
		$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, want);
		err_cnt++;
	endtask

	task automatic abort_run(input string what);
		$display("ERROR t=%0t timed out waiting for %s", $time, what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, err_cnt - err_base);
		err_base = err_cnt;
		tests_run++;
	endtask

	task automatic tick;
		@(posedge clk);
		#1;
		if (random_ready) begin
			out_ready = (rand_bits(1) != 0);
		end
	endtask

	task automatic send_req(input div_pkg::data_t dividend, input div_pkg::data_t divisor);
		int   tries;
		logic taken;
		in_req.tag      = next_tag;
		in_req.dividend = dividend;
		in_req.divisor  = divisor;
		in_valid        = 1'b1;
		next_tag++;
		tries = 0;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			tick;
			tries++;
			if (!taken && tries > wait_limit) begin
				abort_run("in_ready");
			end
		end
		accept_edge = edge_cnt;
		in_valid    = 1'b0;
	endtask

	task automatic wait_out_valid;
		int tries;
		tries = 0;
		while (out_valid !== 1'b1) begin
			tick;
			tries++;
			if (tries > wait_limit) begin
				abort_run("out_valid");
			end
		end
	endtask

	task automatic drain;
		int tries;
		random_ready = 1'b0;
		out_ready    = 1'b1;
		tries        = 0;
		while (exp_q.size() != 0) begin
			tick;
			tries++;
			if (tries > wait_limit) begin
				abort_run("outstanding responses");
			end
		end
	endtask

	// --------------------------------------------------------------------------
	// Scoreboard, sampled mid-cycle so both handshakes are settled
	// --------------------------------------------------------------------------

	always @(negedge clk) begin : monitor
		div_pkg::div_rsp_t want;
		if (rst_n) begin
			if (in_ready !== (!out_valid || out_ready)) begin
				report_mismatch("in_ready", in_ready, !out_valid || out_ready);
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(model_div(in_req));
				n_sent++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("ERROR t=%0t response with tag %0d has no request outstanding",
						$time, out_rsp.tag);
					err_cnt++;
				end else begin
					want = exp_q.pop_front();
					n_recv++;
					if (out_rsp.tag !== want.tag) begin
						report_mismatch("out_rsp.tag", out_rsp.tag, want.tag);
					end
					if (out_rsp.quotient !== want.quotient) begin
						report_mismatch("out_rsp.quotient", out_rsp.quotient, want.quotient);
					end
					if (out_rsp.remainder !== want.remainder) begin
						report_mismatch("out_rsp.remainder", out_rsp.remainder, want.remainder);
					end
					if (out_rsp.div_zero !== want.div_zero) begin
						report_mismatch("out_rsp.div_zero", out_rsp.div_zero, want.div_zero);
					end
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// Tests
	// --------------------------------------------------------------------------

	initial begin : main
		int tries;
		int stall;
		int edge_a;
		int edge_b;
		int total;
		int edge_dvd [12];
		int edge_dvs [12];
		in_valid  = 1'b0;
		in_req    = '0;
		out_ready = 1'b0;
		tries     = 0;
		while (rst_n !== 1'b1) begin
			tick;
			tries++;
			if (tries > wait_limit) begin
				abort_run("reset release");
			end
		end

		// Idle after reset, in_ready high even with out_ready low
		if (out_valid !== 1'b0) begin
			report_mismatch("out_valid", out_valid, 0);
		end
		if (in_ready !== 1'b1) begin
			report_mismatch("in_ready", in_ready, 1);
		end
		finish_test(6, "reset state");

		out_ready = 1'b1;
		for (int i = 0; i < 300; i++) begin
			send_req(div_pkg::data_t'(rand_bits(16)), div_pkg::data_t'(rand_bits(16)));
		end
		drain();
		finish_test(1, "random operands");

		for (int i = 0; i < 20; i++) begin
			send_req(div_pkg::data_t'(rand_bits(16)), '0);
			send_req(div_pkg::data_t'(rand_bits(16)), div_pkg::data_t'(rand_bits(15) + 1));
		end
		drain();
		finish_test(2, "divide by zero");

		// 16-bit operand extremes
		edge_dvd = '{-32768, -32768, 32767, -32768, 1234, -1234, 0, 0, -7, 7, 32767, -32768};
		edge_dvs = '{-1, 1, -1, -32768, 1234, -1234, 7, -7, 1, -1, -32768, 2};
		for (int i = 0; i < 12; i++) begin
			send_req(div_pkg::data_t'(edge_dvd[i]), div_pkg::data_t'(edge_dvs[i]));
		end
		drain();
		finish_test(3, "edge operands");

		random_ready = 1'b1;
		for (int i = 0; i < 200; i++) begin
			repeat (rand_bits(2)) tick;
			send_req(div_pkg::data_t'(rand_bits(16)), div_pkg::data_t'(rand_bits(16)));
		end
		drain();
		finish_test(4, "back-pressure");

		// out_valid rose on the last edge, so the next edge is the first to sample it
		send_req(16'sd100, 16'sd7);
		wait_out_valid();
		if (edge_cnt + 1 - accept_edge != latency) begin
			report_mismatch("latency", edge_cnt + 1 - accept_edge, latency);
		end
		drain();

		// Second request sits behind the first while the output is blocked
		out_ready = 1'b0;
		stall     = 1 + rand_bits(3);
		send_req(-16'sd999, 16'sd10);
		edge_a = accept_edge;
		send_req(16'sd555, -16'sd4);
		edge_b = accept_edge;
		wait_out_valid();
		if (edge_cnt + 1 - edge_a != latency) begin
			report_mismatch("latency", edge_cnt + 1 - edge_a, latency);
		end
		repeat (stall) tick;
		out_ready = 1'b1;
		tick;
		if (out_valid !== 1'b1) begin
			report_mismatch("out_valid", out_valid, 1);
		end
		if (edge_cnt + 1 - edge_b != latency + stall) begin
			report_mismatch("stalled latency", edge_cnt + 1 - edge_b, latency + stall);
		end
		drain();
		finish_test(5, "latency");

		if (n_recv != n_sent) begin
			report_mismatch("response count", n_recv, n_sent);
		end
		total = err_cnt + div_top_i.div_checker_i.err_cnt;
		$display("%0d tests, %0d requests, %0d check errors, %0d assertion failures",
			tests_run, n_sent, err_cnt, div_top_i.div_checker_i.err_cnt);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
